// ==== build.f ====
design/boa_exec_pkg.sv
design/boa_delay_comp.sv
design/boa_unary_enc.sv
design/boa_sel_enc.sv
design/boa_alu.sv
design/boa_mul.sv
design/boa_exec_core.sv
design/boa_apb_regs.sv
design/boa_exec_top.sv
tests/boa_exec_tb.sv

// ==== design/boa_alu.sv ====
// Single-cycle ALU; result and flag hold until the next start, OP_MUL gives zero.
`default_nettype none

module boa_alu
    import boa_exec_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            start,
    input  wire op_t             op,
    input  wire logic [XLEN-1:0] opa,
    input  wire logic [XLEN-1:0] opb,
    output logic      [XLEN-1:0] result,
    output logic                 flag,
    output logic                 valid
);

    logic [XLEN:0]   wide;
    logic [XLEN-1:0] res_d;
    logic            flag_d;

    always_comb begin
        wide   = '0;
        res_d  = '0;
        flag_d = 1'b0;
        unique case (op)
            // Bit XLEN is carry on add, borrow on sub.
            OP_ADD: wide = {1'b0, opa} + {1'b0, opb};
            OP_SUB: wide = {1'b0, opa} - {1'b0, opb};
            OP_AND: res_d = opa & opb;
            OP_OR:  res_d = opa | opb;
            OP_XOR: res_d = opa ^ opb;
            OP_SLL: res_d = opa << opb[4:0];
            OP_SRL: res_d = opa >> opb[4:0];
            default: res_d = '0;
        endcase
        if (op == OP_ADD || op == OP_SUB) begin
            res_d  = wide[XLEN-1:0];
            flag_d = wide[XLEN];
        end
    end

    // Payload captured only on start.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            flag   <= 1'b0;
        end else if (start) begin
            result <= res_d;
            flag   <= flag_d;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) valid <= 1'b0;
        else         valid <= start;
    end

endmodule

`default_nettype wire

// ==== design/boa_apb_regs.sv ====
// APB3 register file; no wait states, bad offsets and refused commands flag pslverr.
`default_nettype none

module boa_apb_regs
    import boa_exec_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic [4:0]                   paddr,
    input  wire logic                         psel,
    input  wire logic                         penable,
    input  wire logic                         pwrite,
    input  wire logic [31:0]                  pwdata,
    output logic      [31:0]                  prdata,
    output logic                              pready,
    output logic                              pslverr,
    output logic      [XLEN-1:0]              opa,
    output logic      [XLEN-1:0]              opb,
    output op_t                               op,
    output logic                              start,
    input  wire logic [XLEN-1:0]              result,
    input  wire logic                         flag,
    input  wire logic                         busy,
    input  wire logic                         done,
    input  wire logic [$clog2(NUM_UNITS)-1:0] last_unit
);

    logic        access;
    logic        known;
    logic        ro_write;
    logic        cmd_bad;
    logic        cmd_ok;
    logic [31:0] status;

    // Access phase completes every cycle it is seen.
    assign access = psel && penable;
    assign pready = 1'b1;

    // Offset decode.
    assign known = (paddr == REG_OPA) || (paddr == REG_OPB) || (paddr == REG_CMD)
                || (paddr == REG_RESULT) || (paddr == REG_STATUS);
    assign ro_write = pwrite && ((paddr == REG_RESULT) || (paddr == REG_STATUS));
    // Command refused while busy or with upper bits set.
    assign cmd_bad  = pwrite && (paddr == REG_CMD) && (busy || (|pwdata[31:3]));
    assign cmd_ok   = access && pwrite && (paddr == REG_CMD) && !cmd_bad;

    assign pslverr = access && (!known || ro_write || cmd_bad);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opa   <= '0;
            opb   <= '0;
            op    <= OP_ADD;
            start <= 1'b0;
        end else begin
            // One-cycle pulse per accepted command.
            start <= cmd_ok;
            if (access && pwrite && paddr == REG_OPA) opa <= pwdata;
            if (access && pwrite && paddr == REG_OPB) opb <= pwdata;
            if (cmd_ok) op <= op_t'(pwdata[2:0]);
        end
    end

    // Status word.
    always_comb begin
        status            = '0;
        status[STAT_BUSY] = busy;
        status[STAT_DONE] = done;
        status[STAT_FLAG] = flag;
        status[STAT_UNIT +: $clog2(NUM_UNITS)] = last_unit;
    end

    // Read mux.
    always_comb begin
        unique case (paddr)
            REG_OPA:    prdata = opa;
            REG_OPB:    prdata = opb;
            REG_CMD:    prdata = {29'b0, op};
            REG_RESULT: prdata = result;
            REG_STATUS: prdata = status;
            default:    prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/boa_delay_comp.sv ====
// Busy timer; a trigger that arrives while the timer still runs is ignored.
`default_nettype none

module boa_delay_comp #(
    parameter int delay = 1
) (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic trig,
    output logic      waiting
);

    generate
        if (delay != 0) begin : g_timer
            // Wide enough to hold delay itself.
            localparam int cnt_w = $clog2(delay + 1);

            logic [cnt_w-1:0] timer;

            // Load on trigger when idle, then count down.
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    timer <= '0;
                end else if (trig && timer == '0) begin
                    timer <= cnt_w'(delay);
                end else if (timer != '0) begin
                    timer <= timer - 1'b1;
                end
            end

            assign waiting = (timer != '0);
        end else begin : g_none
            // No latency to cover.
            assign waiting = 1'b0;
        end
    endgenerate

endmodule

`default_nettype wire

// ==== design/boa_exec_core.sv ====
// Execute core; issues one operation at a time, start must not come while busy.
`default_nettype none

module boa_exec_core
    import boa_exec_pkg::*;
#(
    parameter int MUL_DELAY = 3
) (
    input  wire logic                         clk,
    input  wire logic                         arst_n,
    input  wire logic                         start,
    input  wire op_t                          op,
    input  wire logic [XLEN-1:0]              opa,
    input  wire logic [XLEN-1:0]              opb,
    output logic      [XLEN-1:0]              result,
    output logic                              flag,
    output logic                              busy,
    output logic                              done,
    output logic      [$clog2(NUM_UNITS)-1:0] last_unit
);

    logic                         alu_start, mul_start;
    logic                         alu_wait, mul_wait;
    logic [NUM_UNITS-1:0]         unit_valid;
    logic [XLEN-1:0]              unit_result [NUM_UNITS];
    logic                         unit_flag [NUM_UNITS];
    logic [XLEN-1:0]              merged_result;
    logic                         merged_flag;
    logic [$clog2(NUM_UNITS)-1:0] unit_idx;

    // Route start by operation.
    assign mul_start = start && (op == OP_MUL);
    assign alu_start = start && (op != OP_MUL);

    boa_alu i_alu (
        .clk(clk), .arst_n(arst_n), .start(alu_start), .op(op), .opa(opa), .opb(opb),
        .result(unit_result[UNIT_ALU]), .flag(unit_flag[UNIT_ALU]),
        .valid(unit_valid[UNIT_ALU])
    );

    boa_mul #(.MUL_DELAY(MUL_DELAY)) i_mul (
        .clk(clk), .arst_n(arst_n), .start(mul_start), .opa(opa), .opb(opb),
        .result(unit_result[UNIT_MUL]), .flag(unit_flag[UNIT_MUL]),
        .valid(unit_valid[UNIT_MUL])
    );

    // Cover each unit's latency plus the capture cycle.
    boa_delay_comp #(.delay(1)) i_alu_dc (
        .clk(clk), .arst_n(arst_n), .trig(alu_start), .waiting(alu_wait)
    );
    boa_delay_comp #(.delay(MUL_DELAY)) i_mul_dc (
        .clk(clk), .arst_n(arst_n), .trig(mul_start), .waiting(mul_wait)
    );

    // Start counts too, so a second command is refused at once.
    assign busy = start | alu_wait | mul_wait;

    boa_sel_enc #(.depth(NUM_UNITS), .payload_t(logic [XLEN-1:0])) i_res_sel (
        .sel(unit_valid), .d(unit_result), .q(merged_result)
    );
    boa_sel_enc #(.depth(NUM_UNITS), .payload_t(logic)) i_flag_sel (
        .sel(unit_valid), .d(unit_flag), .q(merged_flag)
    );
    boa_unary_enc #(.width(NUM_UNITS)) i_unit_enc (
        .unary(unit_valid), .binary(unit_idx)
    );

    // Capture on any unit valid; done cleared by the next start.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result    <= '0;
            flag      <= 1'b0;
            done      <= 1'b0;
            last_unit <= '0;
        end else if (|unit_valid) begin
            result    <= merged_result;
            flag      <= merged_flag;
            done      <= 1'b1;
            last_unit <= unit_idx;
        end else if (start) begin
            done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/boa_exec_pkg.sv ====
// Shared constants for the execute subsystem; offsets assume a 5-bit APB address.
`default_nettype none

package boa_exec_pkg;

    // Data path width.
    localparam int XLEN = 32;

    // Operation codes, as written to CMD[2:0].
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_MUL = 3'd7
    } op_t;

    // Functional units.
    // Index doubles as bit position in done vectors.
    localparam int NUM_UNITS = 2;
    localparam int UNIT_ALU  = 0;
    localparam int UNIT_MUL  = 1;

    // APB register offsets.
    localparam logic [4:0] REG_OPA    = 5'h00;
    localparam logic [4:0] REG_OPB    = 5'h04;
    localparam logic [4:0] REG_CMD    = 5'h08;
    localparam logic [4:0] REG_RESULT = 5'h0C;
    localparam logic [4:0] REG_STATUS = 5'h10;

    // STATUS bit positions.
    localparam int STAT_BUSY = 0;
    localparam int STAT_DONE = 1;
    localparam int STAT_FLAG = 2;
    // Unit field, $clog2(NUM_UNITS) bits wide.
    localparam int STAT_UNIT = 4;

endpackage

`default_nettype wire

// ==== design/boa_exec_top.sv ====
// Execute subsystem top; APB3 slave, one clock, MUL_DELAY must be at least 1.
`default_nettype none

module boa_exec_top
    import boa_exec_pkg::*;
#(
    parameter int MUL_DELAY = 3
) (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic [4:0]  paddr,
    input  wire logic        psel,
    input  wire logic        penable,
    input  wire logic        pwrite,
    input  wire logic [31:0] pwdata,
    output logic      [31:0] prdata,
    output logic             pready,
    output logic             pslverr
);

    // Register file to core.
    logic [XLEN-1:0]              opa, opb;
    op_t                          op;
    logic                         start;
    // Core back to register file.
    logic [XLEN-1:0]              result;
    logic                         flag, busy, done;
    logic [$clog2(NUM_UNITS)-1:0] last_unit;

    boa_apb_regs i_regs (
        .clk(clk), .arst_n(arst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .opa(opa), .opb(opb), .op(op), .start(start),
        .result(result), .flag(flag), .busy(busy), .done(done), .last_unit(last_unit)
    );

    boa_exec_core #(.MUL_DELAY(MUL_DELAY)) i_core (
        .clk(clk), .arst_n(arst_n), .start(start), .op(op), .opa(opa), .opb(opb),
        .result(result), .flag(flag), .busy(busy), .done(done), .last_unit(last_unit)
    );

endmodule

`default_nettype wire

// ==== design/boa_mul.sv ====
// Unsigned multiplier pipeline; MUL_DELAY must be at least 1.
`default_nettype none

module boa_mul
    import boa_exec_pkg::*;
#(
    parameter int MUL_DELAY = 3
) (
    input  wire logic            clk,
    input  wire logic            arst_n,
    input  wire logic            start,
    input  wire logic [XLEN-1:0] opa,
    input  wire logic [XLEN-1:0] opb,
    output logic      [XLEN-1:0] result,
    output logic                 flag,
    output logic                 valid
);

    logic [2*XLEN-1:0]  prod_q [MUL_DELAY];
    logic [MUL_DELAY-1:0] vld_q;

    // Full product enters the first stage on start.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < MUL_DELAY; i++) begin
                prod_q[i] <= '0;
            end
        end else begin
            if (start) begin
                prod_q[0] <= opa * opb;
            end
            for (int i = 1; i < MUL_DELAY; i++) begin
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

    // Valid tag rides alongside the data.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start;
            for (int i = 1; i < MUL_DELAY; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // Low word out, overflow when high word non-zero.
    assign result = prod_q[MUL_DELAY-1][XLEN-1:0];
    assign flag   = |prod_q[MUL_DELAY-1][2*XLEN-1:XLEN];
    assign valid  = vld_q[MUL_DELAY-1];

endmodule

`default_nettype wire

// ==== design/boa_sel_enc.sv ====
// Select-and-merge mux; payload_t must be an integral type, sel normally one-hot.
`default_nettype none

module boa_sel_enc #(
    parameter int  depth     = 2,
    parameter type payload_t = logic
) (
    input  wire logic [depth-1:0] sel,
    input  wire payload_t         d [depth],
    output payload_t              q
);

    payload_t masked [depth];

    // Zero every input whose select is low.
    generate
        for (genvar x = 0; x < depth; x++) begin : g_mask
            assign masked[x] = sel[x] ? d[x] : payload_t'(0);
        end
    endgenerate

    // Merge the survivors.
    always_comb begin
        q = payload_t'(0);
        for (int i = 0; i < depth; i++) begin
            q = q | masked[i];
        end
    end

endmodule

`default_nettype wire

// ==== design/boa_unary_enc.sv ====
// One-hot to index encoder; several set bits give the OR of their indices.
`default_nettype none

module boa_unary_enc #(
    parameter int width = 2
) (
    input  wire logic [width-1:0]         unary,
    output logic      [$clog2(width)-1:0] binary
);

    localparam int out_w = $clog2(width);

    // OR the index of every set bit.
    always_comb begin
        binary = '0;
        for (int i = 0; i < width; i++) begin
            if (unary[i]) begin
                binary = binary | out_w'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module boa_exec_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vboa_exec_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Everything OK" sim.log; then
    exit 0
fi
exit 1

// ==== tests/boa_exec_tb.sv ====
// Testbench for boa_exec_top with MUL_DELAY=3; APB has no wait states, run bounded by loop timeouts.
`default_nettype none

module boa_exec_tb
    import boa_exec_pkg::*;
();

    localparam int MUL_DELAY = 3;

    logic        clk;
    logic        arst_n;
    logic [4:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          errors;
    int          checks;
    logic [31:0] rng_state;

    boa_exec_top #(.MUL_DELAY(MUL_DELAY)) i_boa_exec_top (
        .clk(clk), .arst_n(arst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Expected {flag, result} from the unit rules.
    function automatic logic [32:0] model_op(input logic [2:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [63:0] prod;
        logic [31:0] r;
        logic        f;
        prod = 64'(a) * 64'(b);
        r    = '0;
        f    = 1'b0;
        case (op)
            OP_ADD: begin
                r = a + b;
                // Carry out when the sum wraps.
                f = (r < a);
            end
            OP_SUB: begin
                r = a - b;
                f = (a < b);
            end
            OP_AND: r = a & b;
            OP_OR:  r = a | b;
            OP_XOR: r = a ^ b;
            OP_SLL: r = a << b[4:0];
            OP_SRL: r = a >> b[4:0];
            default: begin
                r = prod[31:0];
                f = (prod[63:32] != 32'h0);
            end
        endcase
        return {f, r};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // One APB transfer; returns after the completing edge plus drive delay.
    task automatic apb_transfer(input logic [4:0] addr, input logic wr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int waits;
        logic got;
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2 penable = 1'b1;
        waits = 0;
        got   = 1'b0;
        rdata = '0;
        err   = 1'b0;
        // Sample mid-cycle, where the access phase outputs are stable.
        while (!got && waits < 10) begin
            @(negedge clk);
            if (pready) begin
                got   = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end
            waits++;
        end
        if (!got) begin
            $display("APB access to offset %h never completed, pready stayed low", addr);
            errors++;
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data, output logic err);
        logic [31:0] unused_rd;
        apb_transfer(addr, 1'b1, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data, output logic err);
        apb_transfer(addr, 1'b0, 32'h0, data, err);
    endtask

    // Read STATUS until done, at most 50 polls.
    task automatic wait_done(output logic [31:0] status);
        int polls;
        logic err;
        polls  = 0;
        status = '0;
        while (!status[STAT_DONE] && polls < 50) begin
            apb_read(REG_STATUS, status, err);
            polls++;
        end
        if (!status[STAT_DONE]) begin
            $display("STATUS.done never rose within 50 polls at t=%0t", $time);
            errors++;
        end
    endtask

    task automatic draw_operands(output logic [31:0] a, output logic [31:0] b);
        rng_state = xorshift32(rng_state);
        a = rng_state;
        rng_state = xorshift32(rng_state);
        b = rng_state;
    endtask

    // Full command over APB and compare against the model.
    task automatic run_op(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b);
        logic [32:0] exp;
        logic [31:0] status;
        logic [31:0] res;
        logic        err;
        exp = model_op(op, a, b);
        apb_write(REG_OPA, a, err);
        apb_write(REG_OPB, b, err);
        apb_write(REG_CMD, {29'h0, op}, err);
        check_value("pslverr on CMD", 32'h0, {31'h0, err});
        wait_done(status);
        apb_read(REG_RESULT, res, err);
        check_value("RESULT", exp[31:0], res);
        check_value("STATUS.flag", {31'h0, exp[32]}, {31'h0, status[STAT_FLAG]});
        check_value("STATUS.unit", (op == OP_MUL) ? 32'h1 : 32'h0, {31'h0, status[STAT_UNIT]});
    endtask

    // Count rising edges after a CMD access until done is seen.
    task automatic count_latency(output int edges);
        logic seen;
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < 20) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            seen = i_boa_exec_top.done;
        end
        // Back to the drive point after a rising edge.
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        $display("test %-14s %s, %0d errors", name,
                 (errors == errs_at_start) ? "ok" : "bad", errors - errs_at_start);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rd;
        logic [31:0] st_before;
        logic [32:0] exp_mul;
        logic        err;
        int          mark;
        int          edges;
        errors    = 0;
        checks    = 0;
        rng_state = 32'hba4d;
        arst_n    = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        repeat (2) @(posedge clk);
        #2 arst_n = 1'b1;

        // Reset values and plain register access.
        mark = errors;
        apb_read(REG_STATUS, rd, err);
        check_value("STATUS after reset", 32'h0, rd);
        check_value("pslverr on STATUS read", 32'h0, {31'h0, err});
        apb_write(REG_OPA, 32'hdead_beef, err);
        apb_write(REG_OPB, 32'h1234_5678, err);
        apb_read(REG_OPA, rd, err);
        check_value("OPA", 32'hdead_beef, rd);
        apb_read(REG_OPB, rd, err);
        check_value("OPB", 32'h1234_5678, rd);
        apb_read(5'h14, rd, err);
        check_value("pslverr on unknown offset", 32'h1, {31'h0, err});
        apb_write(REG_RESULT, 32'h1, err);
        check_value("pslverr on RESULT write", 32'h1, {31'h0, err});
        end_test("reset_regs", mark);

        // Seven ALU codes, 20 pairs each.
        mark = errors;
        for (int k = 0; k < 7; k++) begin
            for (int n = 0; n < 20; n++) begin
                draw_operands(a, b);
                run_op(3'(k), a, b);
            end
        end
        end_test("alu_ops", mark);

        // Multiplier, with small operands for a clear flag.
        mark = errors;
        for (int n = 0; n < 10; n++) begin
            draw_operands(a, b);
            if (n[0]) begin
                a = a & 32'h0000_ffff;
                b = b & 32'h0000_ffff;
            end
            run_op(OP_MUL, a, b);
        end
        run_op(OP_MUL, 32'hffff_ffff, 32'h2);
        end_test("multiplier", mark);

        // Second CMD straight after a multiply is refused.
        mark = errors;
        draw_operands(a, b);
        exp_mul = model_op(OP_MUL, a, b);
        apb_write(REG_OPA, a, err);
        apb_write(REG_OPB, b, err);
        apb_write(REG_CMD, {29'h0, OP_MUL}, err);
        check_value("pslverr on first CMD", 32'h0, {31'h0, err});
        apb_write(REG_CMD, {29'h0, OP_ADD}, err);
        check_value("pslverr on busy CMD", 32'h1, {31'h0, err});
        wait_done(rd);
        apb_read(REG_RESULT, rd, err);
        check_value("RESULT after refusal", exp_mul[31:0], rd);
        apb_read(REG_CMD, rd, err);
        check_value("CMD readback", {29'h0, OP_MUL}, rd);
        end_test("busy_refusal", mark);

        // Upper command bits set.
        mark = errors;
        apb_read(REG_STATUS, st_before, err);
        apb_write(REG_CMD, 32'h0000_0008, err);
        check_value("pslverr on bad CMD", 32'h1, {31'h0, err});
        apb_read(REG_STATUS, rd, err);
        check_value("STATUS.busy", {31'h0, st_before[STAT_BUSY]}, {31'h0, rd[STAT_BUSY]});
        check_value("STATUS.done", {31'h0, st_before[STAT_DONE]}, {31'h0, rd[STAT_DONE]});
        end_test("invalid_cmd", mark);

        // Edge counts from the CMD access to done.
        mark = errors;
        apb_write(REG_CMD, {29'h0, OP_XOR}, err);
        count_latency(edges);
        check_value("ALU latency", 32'd2, 32'(edges));
        apb_write(REG_CMD, {29'h0, OP_MUL}, err);
        count_latency(edges);
        check_value("MUL latency", 32'(MUL_DELAY + 1), 32'(edges));
        end_test("latency", mark);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
